//--- src/cam_display_consts.svh
`ifndef CAM_DISPLAY_CONSTS_SVH
`define CAM_DISPLAY_CONSTS_SVH

// ======================================================================
// default vga timing, 640x480 at 25 MHz pixel clock
// ======================================================================

// horizontal, in pixels
`define VGA_H_ACTIVE 640
`define VGA_H_FRONT  16
`define VGA_H_SYNC   96
`define VGA_H_BACK   48

// vertical, in lines
`define VGA_V_ACTIVE 480
`define VGA_V_FRONT  10
`define VGA_V_SYNC   2
`define VGA_V_BACK   33

// ======================================================================
// latencies
// ======================================================================

`define MEM_RD_LAT 2  // address in -> data out of frame buffer
`define PIPE_LAT   3  // counter state -> registered vga outputs

// ======================================================================
// remote key codes
// ======================================================================

`define KEY_GRAY 8'h0F  // grayscale view
`define KEY_ORIG 8'h12  // original colour ("ok" key)

`endif

//--- src/cam_display_pkg.sv
package cam_display_pkg;

    // plain vectors with a meaning
    typedef logic [16:0] fb_addr_t;   // frame buffer word address
    typedef logic [15:0] rgb565_t;    // stored pixel, r5 g6 b5
    typedef logic [7:0]  chan_t;      // one 8 bit colour channel
    typedef logic [7:0]  key_code_t;  // decoded remote key

    // full colour pixel towards the dac
    typedef struct packed {
        chan_t r;
        chan_t g;
        chan_t b;
    } rgb888_t;

    // sync group, syncs are active low
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic blank_n;  // high only on visible pixels
    } vga_sync_t;

    // frame buffer write port
    typedef struct packed {
        logic     en;
        fb_addr_t addr;
        rgb565_t  data;
    } fb_wr_t;

    typedef enum logic {
        mode_orig,
        mode_gray
    } disp_mode_e;

    // display enable sequence
    typedef enum logic [1:0] {
        st_wait_load,   // nothing complete in the buffer yet
        st_wait_vsync,  // frame loaded, hold black until a frame boundary
        st_show
    } disp_state_e;

endpackage

//--- src/vga_timing.sv
`timescale 1ns/1ps
`include "cam_display_consts.svh"

module vga_timing import cam_display_pkg::*; #(
    parameter int h_active = `VGA_H_ACTIVE,
    parameter int h_front  = `VGA_H_FRONT,
    parameter int h_sync   = `VGA_H_SYNC,
    parameter int h_back   = `VGA_H_BACK,
    parameter int v_active = `VGA_V_ACTIVE,
    parameter int v_front  = `VGA_V_FRONT,
    parameter int v_sync   = `VGA_V_SYNC,
    parameter int v_back   = `VGA_V_BACK
) (
    input  logic      clk_25_vga,
    input  logic      rst,
    output vga_sync_t raw_sync,
    output fb_addr_t  rd_addr
);

    localparam int h_total = h_active + h_front + h_sync + h_back;
    localparam int v_total = v_active + v_front + v_sync + v_back;
    localparam int xw = $clog2(h_total + 1);  // +1 so every boundary fits
    localparam int yw = $clog2(v_total + 1);

    // region boundaries, order is active / front / sync / back
    localparam logic [xw-1:0] x_last     = xw'(h_total - 1);
    localparam logic [xw-1:0] x_act_end  = xw'(h_active);
    localparam logic [xw-1:0] x_hs_start = xw'(h_active + h_front);
    localparam logic [xw-1:0] x_hs_end   = xw'(h_active + h_front + h_sync);
    localparam logic [yw-1:0] y_last     = yw'(v_total - 1);
    localparam logic [yw-1:0] y_act_end  = yw'(v_active);
    localparam logic [yw-1:0] y_vs_start = yw'(v_active + v_front);
    localparam logic [yw-1:0] y_vs_end   = yw'(v_active + v_front + v_sync);

    localparam fb_addr_t half_w = fb_addr_t'(h_active / 2);  // stored pixels per row

    logic [xw-1:0] x;
    logic [yw-1:0] y;
    fb_addr_t      line_base;  // (y/2) * half_w, kept as a running sum
    logic          active;

    // ======================================================================
    // counters
    // ======================================================================

    always_ff @(posedge clk_25_vga) begin
        if (rst) begin
            x         <= '0;
            y         <= '0;
            line_base <= '0;
        end else if (x == x_last) begin
            x <= '0;
            if (y == y_last) begin
                y         <= '0;
                line_base <= '0;  // back to row 0 of the buffer
            end else begin
                y <= y + 1'b1;
                // every second line moves one buffer row down
                if (y[0] && (y < y_act_end)) begin
                    line_base <= line_base + half_w;
                end
            end
        end else begin
            x <= x + 1'b1;
        end
    end

    // ======================================================================
    // decode
    // ======================================================================

    assign active = (x < x_act_end) && (y < y_act_end);

    assign raw_sync.hsync   = !((x >= x_hs_start) && (x < x_hs_end));
    assign raw_sync.vsync   = !((y >= y_vs_start) && (y < y_vs_end));
    assign raw_sync.blank_n = active;

    // 2x2 pixel doubling: x/2 on top of the row base
    assign rd_addr = active ? (line_base + fb_addr_t'(x >> 1)) : '0;

endmodule

//--- src/frame_buffer.sv
`timescale 1ns/1ps
`include "cam_display_consts.svh"

module frame_buffer import cam_display_pkg::*; #(
    parameter int depth = (`VGA_H_ACTIVE / 2) * (`VGA_V_ACTIVE / 2)
) (
    input  logic     clk_25_vga,
    input  logic     rst,
    input  fb_wr_t   fb_wr,
    input  fb_addr_t rd_addr,
    output rgb565_t  rd_data,
    output logic     frame_loaded
);

    localparam int       aw        = $clog2(depth);
    localparam fb_addr_t last_addr = fb_addr_t'(depth - 1);

    rgb565_t mem [depth];
    rgb565_t rd_pipe [`MEM_RD_LAT];  // ram output reg plus extra stages
    logic    wr_hit;

    // writes beyond the array are dropped
    assign wr_hit = fb_wr.en && (fb_wr.addr < fb_addr_t'(depth));

    always_ff @(posedge clk_25_vga) begin
        if (wr_hit) begin
            mem[fb_wr.addr[aw-1:0]] <= fb_wr.data;
        end
    end

    // registered read, data valid MEM_RD_LAT cycles after rd_addr
    always_ff @(posedge clk_25_vga) begin
        rd_pipe[0] <= mem[rd_addr[aw-1:0]];
        for (int i = 1; i < `MEM_RD_LAT; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    assign rd_data = rd_pipe[`MEM_RD_LAT-1];

    // last location written => one complete frame in memory
    always_ff @(posedge clk_25_vga) begin
        if (rst) begin
            frame_loaded <= 1'b0;
        end else begin
            frame_loaded <= fb_wr.en && (fb_wr.addr == last_addr);  // 1 cycle pulse
        end
    end

endmodule

//--- src/display_ctrl.sv
`timescale 1ns/1ps
`include "cam_display_consts.svh"

module display_ctrl import cam_display_pkg::*; (
    input  logic       clk_25_vga,
    input  logic       rst,
    input  key_code_t  key_code,
    input  logic       key_valid,
    input  logic       frame_loaded,
    input  logic       vsync,
    output disp_mode_e mode,
    output logic       show
);

    disp_state_e state;
    disp_state_e state_nxt;
    logic        vsync_q;     // previous vsync for edge detect
    logic        vsync_rise;  // end of the sync pulse

    // ======================================================================
    // display mode from remote keys
    // ======================================================================

    always_ff @(posedge clk_25_vga) begin
        if (rst) begin
            mode <= mode_orig;
        end else if (key_valid) begin  // code only looked at with the strobe
            case (key_code)
                `KEY_GRAY: mode <= mode_gray;
                `KEY_ORIG: mode <= mode_orig;
                default:   mode <= mode;  // any other key keeps the mode
            endcase
        end
    end

    // ======================================================================
    // display enable
    // ======================================================================

    assign vsync_rise = vsync && !vsync_q;

    always_ff @(posedge clk_25_vga) begin
        if (rst) begin
            vsync_q <= 1'b1;  // idle level, no false edge out of reset
            state   <= st_wait_load;
        end else begin
            vsync_q <= vsync;
            state   <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_wait_load: begin
                if (frame_loaded) begin
                    state_nxt = st_wait_vsync;
                end
            end
            st_wait_vsync: begin
                if (vsync_rise) begin
                    state_nxt = st_show;
                end
            end
            st_show:  state_nxt = st_show;  // sticky until rst
            default:  state_nxt = st_wait_load;
        endcase
    end

    assign show = (state == st_show);

endmodule

//--- src/pixel_path.sv
`timescale 1ns/1ps
`include "cam_display_consts.svh"

module pixel_path import cam_display_pkg::*; (
    input  logic       clk_25_vga,
    input  logic       rst,
    input  vga_sync_t  raw_sync,
    input  rgb565_t    rd_data,
    input  disp_mode_e mode,
    input  logic       show,
    output vga_sync_t  vga_sync,
    output rgb888_t    vga_rgb
);

    // syncs inactive, blanked
    localparam vga_sync_t sync_idle = '{hsync: 1'b1, vsync: 1'b1, blank_n: 1'b0};

    vga_sync_t   sync_dly [`MEM_RD_LAT];  // rides beside the ram read
    vga_sync_t   sync_al;                 // sync aligned with rd_data
    rgb888_t     color;
    logic [15:0] gray_sum;                // max 252 * 255, fits 16 bits
    chan_t       gray;
    rgb888_t     pix_sel;

    // ======================================================================
    // sync delay, same depth as the frame buffer read
    // ======================================================================

    always_ff @(posedge clk_25_vga) begin
        if (rst) begin
            for (int i = 0; i < `MEM_RD_LAT; i++) begin
                sync_dly[i] <= sync_idle;
            end
        end else begin
            sync_dly[0] <= raw_sync;
            for (int i = 1; i < `MEM_RD_LAT; i++) begin
                sync_dly[i] <= sync_dly[i-1];
            end
        end
    end

    assign sync_al = sync_dly[`MEM_RD_LAT-1];

    // ======================================================================
    // colour expansion and gray
    // ======================================================================

    // low bits filled with ones
    assign color.r = {rd_data[15:11], 3'b111};
    assign color.g = {rd_data[10:5], 2'b11};
    assign color.b = {rd_data[4:0], 3'b111};

    // weights 76/150/26 out of 256
    assign gray_sum = 16'd76 * {8'd0, color.r}
                    + 16'd150 * {8'd0, color.g}
                    + 16'd26 * {8'd0, color.b};
    assign gray = gray_sum[15:8];

    always_comb begin
        case (mode)
            mode_gray: begin
                pix_sel.r = gray;
                pix_sel.g = gray;
                pix_sel.b = gray;
            end
            default: pix_sel = color;
        endcase
    end

    // ======================================================================
    // output register
    // ======================================================================

    always_ff @(posedge clk_25_vga) begin
        if (rst) begin
            vga_sync <= sync_idle;
            vga_rgb  <= '0;
        end else begin
            vga_sync <= sync_al;
            if (sync_al.blank_n && show) begin
                vga_rgb <= pix_sel;
            end else begin
                vga_rgb <= '0;  // black in blanking and before enable
            end
        end
    end

endmodule

//--- src/cam_display_top.sv
`timescale 1ns/1ps
`include "cam_display_consts.svh"

module cam_display_top import cam_display_pkg::*; #(
    parameter int h_active = `VGA_H_ACTIVE,
    parameter int h_front  = `VGA_H_FRONT,
    parameter int h_sync   = `VGA_H_SYNC,
    parameter int h_back   = `VGA_H_BACK,
    parameter int v_active = `VGA_V_ACTIVE,  // active sizes must be even
    parameter int v_front  = `VGA_V_FRONT,
    parameter int v_sync   = `VGA_V_SYNC,
    parameter int v_back   = `VGA_V_BACK
) (
    input  logic      clk_25_vga,
    input  logic      rst,
    input  key_code_t key_code,
    input  logic      key_valid,
    input  fb_wr_t    fb_wr,
    output vga_sync_t vga_sync,
    output rgb888_t   vga_rgb
);

    vga_sync_t  raw_sync;      // undelayed, straight from the counters
    fb_addr_t   rd_addr;
    rgb565_t    rd_data;
    logic       frame_loaded;
    disp_mode_e mode;
    logic       show;

    // ======================================================================
    // timing and storage
    // ======================================================================

    vga_timing #(
        .h_active (h_active),
        .h_front  (h_front),
        .h_sync   (h_sync),
        .h_back   (h_back),
        .v_active (v_active),
        .v_front  (v_front),
        .v_sync   (v_sync),
        .v_back   (v_back)
    ) vga_timing_i (
        .clk_25_vga (clk_25_vga),
        .rst        (rst),
        .raw_sync   (raw_sync),
        .rd_addr    (rd_addr)
    );

    // half resolution buffer, each word shown as 2x2
    frame_buffer #(
        .depth ((h_active / 2) * (v_active / 2))
    ) frame_buffer_i (
        .clk_25_vga   (clk_25_vga),
        .rst          (rst),
        .fb_wr        (fb_wr),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .frame_loaded (frame_loaded)
    );

    // ======================================================================
    // control and pixel output
    // ======================================================================

    display_ctrl display_ctrl_i (
        .clk_25_vga   (clk_25_vga),
        .rst          (rst),
        .key_code     (key_code),
        .key_valid    (key_valid),
        .frame_loaded (frame_loaded),
        .vsync        (raw_sync.vsync),
        .mode         (mode),
        .show         (show)
    );

    pixel_path pixel_path_i (
        .clk_25_vga (clk_25_vga),
        .rst        (rst),
        .raw_sync   (raw_sync),
        .rd_data    (rd_data),
        .mode       (mode),
        .show       (show),
        .vga_sync   (vga_sync),
        .vga_rgb    (vga_rgb)
    );

endmodule

//--- tb/cam_display_props.sv
`timescale 1ns/1ps
`include "cam_display_consts.svh"

module cam_display_props import cam_display_pkg::*; #(
    parameter int h_sync = `VGA_H_SYNC
) (
    input logic      clk_25_vga,
    input logic      rst,
    input vga_sync_t vga_sync,
    input rgb888_t   vga_rgb,
    input logic      frame_loaded
);

    int   hs_len;       // low cycles of the running hsync pulse
    logic loaded_seen;  // sticky after the first complete frame

    always_ff @(posedge clk_25_vga) begin
        if (rst) begin
            hs_len      <= 0;
            loaded_seen <= 1'b0;
        end else begin
            hs_len <= vga_sync.hsync ? 0 : hs_len + 1;
            if (frame_loaded) begin
                loaded_seen <= 1'b1;
            end
        end
    end

    // no colour outside the visible area
    blank_black: assert property (@(posedge clk_25_vga) disable iff (rst)
        !vga_sync.blank_n |-> vga_rgb == '0)
        else $error("rgb is not zero while blank_n is low");

    // pulse length checked when hsync returns high
    hsync_width: assert property (@(posedge clk_25_vga) disable iff (rst)
        $rose(vga_sync.hsync) |-> hs_len == h_sync)
        else $error("hsync low pulse has the wrong length");

    black_before_load: assert property (@(posedge clk_25_vga) disable iff (rst)
        !loaded_seen |-> vga_rgb == '0)
        else $error("rgb is not zero before the first frame was loaded");

endmodule

bind cam_display_top cam_display_props #(.h_sync(h_sync)) cam_display_props_i (
    .clk_25_vga   (clk_25_vga),
    .rst          (rst),
    .vga_sync     (vga_sync),
    .vga_rgb      (vga_rgb),
    .frame_loaded (frame_loaded)
);

//--- tb/cam_display_tb.sv
`timescale 1ns/1ps
`include "cam_display_consts.svh"

module cam_display_tb import cam_display_pkg::*; ();

    // small timing giving a 16 x 8 cycle frame over a 4 x 2 buffer
    localparam int h_active     = 8;
    localparam int h_front      = 2;
    localparam int h_sync       = 3;
    localparam int h_back       = 3;
    localparam int v_active     = 4;
    localparam int v_front      = 1;
    localparam int v_sync       = 2;
    localparam int v_back       = 1;
    localparam int h_total      = h_active + h_front + h_sync + h_back;
    localparam int frame_cycles = h_total * (v_active + v_front + v_sync + v_back);
    localparam int fb_depth     = (h_active / 2) * (v_active / 2);
    localparam int aw           = $clog2(fb_depth);
    localparam int max_cycles   = 20 * frame_cycles + 440;  // about 14 test frames plus slack

    logic      clk_25_vga = 1'b0;
    logic      rst;
    key_code_t key_code;
    logic      key_valid;
    fb_wr_t    fb_wr;
    vga_sync_t vga_sync;
    rgb888_t   vga_rgb;
    logic      out_vsync;

    // expected contents of the design
    rgb565_t     model_mem [fb_depth];
    disp_mode_e  model_mode;
    logic        model_loaded;  // last word written at least once
    logic [31:0] rng_state;

    // checker state latched at every output vsync rise
    rgb565_t    frame_mem [fb_depth];
    disp_mode_e frame_mode;
    logic       frame_show;
    vga_sync_t  sync_q;       // outputs one cycle back
    int         pix_n;        // active pixel index within the frame
    int         line_act;
    int         frame_lines;
    int         vs_low;
    int         pix_checked = 0;
    int         err_count = 0;
    int         cycle_count = 0;

    always #4 clk_25_vga = ~clk_25_vga;  // 8 ns period

    assign out_vsync = vga_sync.vsync;

    cam_display_top #(
        .h_active (h_active),
        .h_front  (h_front),
        .h_sync   (h_sync),
        .h_back   (h_back),
        .v_active (v_active),
        .v_front  (v_front),
        .v_sync   (v_sync),
        .v_back   (v_back)
    ) cam_display_top_i (
        .clk_25_vga (clk_25_vga),
        .rst        (rst),
        .key_code   (key_code),
        .key_valid  (key_valid),
        .fb_wr      (fb_wr),
        .vga_sync   (vga_sync),
        .vga_rgb    (vga_rgb)
    );

    // ======================================================================
    // helpers
    // ======================================================================

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // expected output for one stored pixel
    function automatic rgb888_t ref_pixel(input rgb565_t p, input disp_mode_e m);
        rgb888_t c;
        int      lum;
        c.r = {p[15:11], 3'b111};  // missing low bits read as ones
        c.g = {p[10:5], 2'b11};
        c.b = {p[4:0], 3'b111};
        lum = (76 * int'(c.r) + 150 * int'(c.g) + 26 * int'(c.b)) >> 8;
        if (m == mode_gray) begin
            c.r = chan_t'(lum);
            c.g = chan_t'(lum);
            c.b = chan_t'(lum);
        end
        return c;
    endfunction

    task automatic log_error(input string msg);
        err_count++;
        $display("FAILED at %0d ns: %s", $time, msg);
    endtask

    task automatic wait_frames(input int n);
        repeat (n) @(posedge out_vsync);
    endtask

    // start of the output sync pulse with the next frame still ahead
    task automatic enter_blanking();
        @(negedge out_vsync);
        @(negedge clk_25_vga);
    endtask

    task automatic load_buffer(input int count);
        for (int a = 0; a < count; a++) begin
            rng_state = xorshift32(rng_state);
            fb_wr.en = 1'b1;
            fb_wr.addr = fb_addr_t'(a);
            fb_wr.data = rng_state[15:0];
            model_mem[aw'(a)] = rng_state[15:0];
            if (a == fb_depth - 1) begin
                model_loaded = 1'b1;
            end
            @(negedge clk_25_vga);
        end
        fb_wr = '0;
    endtask

    task automatic press_key(input key_code_t code, input logic strobe);
        key_code = code;
        key_valid = strobe;
        if (strobe && code == `KEY_GRAY) begin
            model_mode = mode_gray;
        end else if (strobe && code == `KEY_ORIG) begin
            model_mode = mode_orig;
        end  // other codes keep the mode
        @(negedge clk_25_vga);
        key_valid = 1'b0;
    endtask

    // ======================================================================
    // stimulus
    // ======================================================================

    initial begin
        rst = 1'b1;
        key_code = '0;
        key_valid = 1'b0;
        fb_wr = '0;
        rng_state = 32'hfd1f_083c;
        model_mem = '{default: '0};
        model_mode = mode_orig;
        model_loaded = 1'b0;
        repeat (4) @(posedge clk_25_vga);
        @(negedge clk_25_vga);
        rst = 1'b0;

        wait_frames(2);              // nothing loaded so all black
        enter_blanking();
        load_buffer(fb_depth - 1);   // last word missing so still black
        wait_frames(2);
        enter_blanking();
        load_buffer(fb_depth);       // complete frame
        wait_frames(2);
        enter_blanking();
        press_key(`KEY_GRAY, 1'b1);
        wait_frames(2);
        enter_blanking();
        press_key(8'h33, 1'b1);      // unknown key
        press_key(`KEY_ORIG, 1'b0);  // mode key without strobe
        wait_frames(2);
        enter_blanking();
        press_key(`KEY_ORIG, 1'b1);
        wait_frames(2);
        enter_blanking();
        load_buffer(fb_depth);       // whole buffer rewritten in blanking
        wait_frames(2);

        $display("pixels checked %0d, errors %0d", pix_checked, err_count);
        if (err_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // ======================================================================
    // output checker
    // ======================================================================

    always @(posedge clk_25_vga) begin
        rgb888_t       exp_pix;
        logic [aw-1:0] idx;
        if (rst) begin
            sync_q = '{hsync: 1'b1, vsync: 1'b1, blank_n: 1'b0};
            frame_show = 1'b0;
            frame_mode = mode_orig;
            pix_n = 0;
            line_act = 0;
            frame_lines = 0;
            vs_low = 0;
        end else begin
            if (vga_sync.vsync && !sync_q.vsync) begin  // end of sync pulse
                assert (frame_lines == v_active)
                    else log_error($sformatf("%0d active lines in frame", frame_lines));
                assert (vs_low == v_sync * h_total)
                    else log_error($sformatf("vsync low for %0d cycles", vs_low));
                pix_n = 0;
                frame_lines = 0;
                vs_low = 0;
                frame_mem = model_mem;
                frame_mode = model_mode;
                frame_show = model_loaded;
            end
            if (!vga_sync.vsync) begin
                vs_low++;
            end
            if (!vga_sync.hsync && sync_q.hsync) begin
                assert (line_act == 0 || line_act == h_active)
                    else log_error($sformatf("%0d active cycles in line", line_act));
                if (line_act == h_active) begin
                    frame_lines++;
                end
                line_act = 0;
            end
            if (vga_sync.blank_n) begin
                exp_pix = '0;
                if (frame_show) begin
                    // pixel n at x = n mod w and y = n div w reads buffer (y/2, x/2)
                    idx = aw'((pix_n / h_active / 2) * (h_active / 2) + (pix_n % h_active) / 2);
                    exp_pix = ref_pixel(frame_mem[idx], frame_mode);
                end
                assert (vga_rgb == exp_pix)
                    else log_error($sformatf("pixel %0d got %h expected %h",
                                             pix_n, vga_rgb, exp_pix));
                line_act++;
                pix_n++;
                pix_checked++;
            end else begin
                assert (vga_rgb == '0)
                    else log_error($sformatf("rgb %h during blanking", vga_rgb));
            end
            sync_q = vga_sync;
        end
    end

    // ======================================================================
    // timeout
    // ======================================================================

    always @(posedge clk_25_vga) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("timeout after %0d cycles, the test sequence did not finish", cycle_count);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

endmodule

//--- flist.f
+incdir+src
src/cam_display_pkg.sv
src/vga_timing.sv
src/frame_buffer.sv
src/display_ctrl.sv
src/pixel_path.sv
src/cam_display_top.sv
tb/cam_display_props.sv
tb/cam_display_tb.sv

//--- Makefile
# Verilator build and run of the camera display testbench
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   this list"

test:
	verilator --binary --timing --assert -f flist.f --top-module cam_display_tb -Mdir obj_dir
	./obj_dir/Vcam_display_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
